// ==== Bender.yml ====
package:
  name: chip8_core

sources:
  - chip8_sys_pkg.sv
  - chip8_isa_pkg.sv
  - chip8_ifs.sv
  - host_port.sv
  - run_control.sv
  - chip8_timers.sv
  - chip8_memory.sv
  - exec_unit.sv
  - chip8_top.sv
  - target: test
    files:
      - tb_chip8.sv

// ==== chip8_ifs.sv ====
// Host access bus and sequencer-to-execution bus used between the blocks of the core
`timescale 1ns/1ps

interface host_if;
    import chip8_sys_pkg::*;

    host_target_e      target;
    logic [MEM_AW-1:0] offset;
    logic [15:0]       wdata;
    logic              we;

    // One read return per responder
    logic [7:0]  rdata_mem;
    logic [15:0] rdata_exec;
    logic [7:0]  rdata_timer;
    logic [15:0] rdata_ctrl;

    modport host  (output target, offset, wdata, we,
                   input  rdata_mem, rdata_exec, rdata_timer, rdata_ctrl);
    modport mem   (input target, offset, wdata, we, output rdata_mem);
    modport exec  (input target, offset, wdata, we, output rdata_exec);
    modport timer (input target, wdata, we, output rdata_timer);
    modport ctrl  (input target, wdata, we, output rdata_ctrl);
endinterface

interface exec_if;
    import chip8_sys_pkg::*;
    import chip8_isa_pkg::*;

    instr_u            instr;
    logic              exec;
    logic [MEM_AW-1:0] pc;
    pc_src_e           pc_src;
    logic [MEM_AW-1:0] pc_target;

    modport ctrl (output instr, exec, pc, input pc_src, pc_target);
    modport unit (input instr, exec, pc, output pc_src, pc_target);
endinterface

// ==== chip8_isa_pkg.sv ====
// Instruction word layout, opcode values and PC update rules shared by sequencer and execution unit
package chip8_isa_pkg;

    typedef struct packed {
        logic [3:0]  op;
        logic [11:0] nnn;
    } addr_form_t;

    typedef struct packed {
        logic [3:0] op;
        logic [3:0] x;
        logic [7:0] kk;
    } imm_form_t;

    typedef struct packed {
        logic [3:0] op;
        logic [3:0] x;
        logic [3:0] y;
        logic [3:0] n;
    } alu_form_t;

    // One instruction word, three decodings
    typedef union packed {
        addr_form_t addr_form;
        imm_form_t  imm_form;
        alu_form_t  alu_form;
    } instr_u;

    localparam logic [3:0] OP_SYS  = 4'h0;
    localparam logic [3:0] OP_JP   = 4'h1;
    localparam logic [3:0] OP_CALL = 4'h2;
    localparam logic [3:0] OP_SE   = 4'h3;
    localparam logic [3:0] OP_SNE  = 4'h4;
    localparam logic [3:0] OP_LD   = 4'h6;
    localparam logic [3:0] OP_ADD  = 4'h7;
    localparam logic [3:0] OP_ALU  = 4'h8;
    localparam logic [3:0] OP_LDI  = 4'hA;
    localparam logic [3:0] OP_MISC = 4'hF;

    localparam logic [7:0] KK_RET      = 8'hEE;
    localparam logic [7:0] KK_LD_VX_DT = 8'h07;
    localparam logic [7:0] KK_LD_DT_VX = 8'h15;
    localparam logic [7:0] KK_LD_ST_VX = 8'h18;

    typedef enum logic [1:0] {NEXT, SKIP, TARGET} pc_src_e;

endpackage

// ==== chip8_memory.sv ====
// Program memory: byte-wide host port plus a registered big-endian 16-bit fetch port
`timescale 1ns/1ps

module chip8_memory (
    input  logic                              clk,
    host_if.mem                               host,
    input  logic [chip8_sys_pkg::MEM_AW-1:0] fetch_addr,
    output logic [15:0]                       fetch_word
);
    import chip8_sys_pkg::*;

    logic [7:0]        mem [MEM_DEPTH];
    logic [MEM_AW-1:0] fetch_next;

    // Second byte wraps at the top of memory
    assign fetch_next = fetch_addr + 1'b1;

    always_ff @(posedge clk) begin
        if (host.target == MEM) begin
            if (host.we) begin
                mem[host.offset] <= host.wdata[7:0];
            end
            host.rdata_mem <= mem[host.offset];
        end
    end

    always_ff @(posedge clk) begin
        fetch_word <= {mem[fetch_addr], mem[fetch_next]};
    end

endmodule

// ==== chip8_sys_pkg.sv ====
// System constants, host address map and run-state/host-target types, imported by every RTL block
package chip8_sys_pkg;

    localparam int MEM_AW      = 12;
    localparam int MEM_DEPTH   = 4096;
    localparam int NUM_VREGS   = 16;
    localparam int STACK_DEPTH = 16;
    localparam int SP_W        = 4;

    localparam logic [MEM_AW-1:0] PC_RESET = 12'h200;

    // Instruction period, scaled down for simulation
    localparam int                 STAGE_W    = 3;
    localparam logic [STAGE_W-1:0] STAGE_LAST = 3'd7;

    // Timer tick period in clocks
    localparam int TICK_DIV = 32;

    localparam int HOST_AW      = 17;
    localparam int HOST_MEM_BIT = 16;

    // Register window below the memory bit
    localparam logic [HOST_MEM_BIT-1:0] HADDR_I     = 16'h0010;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_ST    = 16'h0011;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_DT    = 16'h0012;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_SP    = 16'h0013;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_PC    = 16'h0014;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_STATE = 16'h0016;
    localparam logic [HOST_MEM_BIT-1:0] HADDR_STACK = 16'h0018;

    typedef enum logic [1:0] {
        RUNNING      = 2'd0,
        LOADING_ROM  = 2'd1,
        LOADING_FONT = 2'd2,
        PAUSED       = 2'd3
    } run_state_e;

    typedef enum logic [3:0] {
        NONE, MEM, VREG, IREG, TIMER_ST, TIMER_DT,
        CTRL_PC, CTRL_STATE, STACK_SP, STACK_TOP
    } host_target_e;

endpackage

// ==== chip8_timers.sv ====
// Delay and sound countdown timers with their shared tick divider and sound_on level
`timescale 1ns/1ps

module chip8_timers (
    input  logic       clk,
    input  logic       cpu_fbreset,
    host_if.timer      host,
    input  logic       dt_we,
    input  logic       st_we,
    input  logic [7:0] dt_wdata,
    input  logic [7:0] st_wdata,
    output logic [7:0] dt_value,
    output logic       sound_on
);
    import chip8_sys_pkg::*;

    logic [$clog2(TICK_DIV)-1:0] tick_cnt;
    logic                        tick;
    // Index 0 is the delay timer, 1 the sound timer
    logic [1:0][7:0]             tval;
    logic [1:0]                  wr;
    logic [1:0][7:0]             wval;

    assign tick = (tick_cnt == TICK_DIV - 1);

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
        end
    end

    assign wr[0]   = dt_we | (host.we && host.target == TIMER_DT);
    assign wr[1]   = st_we | (host.we && host.target == TIMER_ST);
    assign wval[0] = dt_we ? dt_wdata : host.wdata[7:0];
    assign wval[1] = st_we ? st_wdata : host.wdata[7:0];

    for (genvar i = 0; i < 2; i++) begin : g_timer
        always_ff @(posedge clk) begin
            if (cpu_fbreset) begin
                tval[i] <= 8'h0;
            end else if (wr[i]) begin
                tval[i] <= wval[i];
            end else if (tick && tval[i] != 8'h0) begin
                tval[i] <= tval[i] - 1'b1;
            end
        end

        a_hold_zero: assert property (@(posedge clk) disable iff (cpu_fbreset)
            tval[i] == 8'h0 && !wr[i] |=> tval[i] == 8'h0);
    end

    always_ff @(posedge clk) begin
        if (host.target == TIMER_DT) begin
            host.rdata_timer <= tval[0];
        end else if (host.target == TIMER_ST) begin
            host.rdata_timer <= tval[1];
        end
    end

    assign dt_value = tval[0];
    assign sound_on = (tval[1] != 8'h0);

endmodule

// ==== chip8_top.sv ====
// Top level of the CHIP-8 control core; connect the host bus here and observe sound_on
`timescale 1ns/1ps

module chip8_top (
    input  logic                               clk,
    input  logic                               cpu_fbreset,
    input  logic                               chipselect,
    input  logic                               write,
    input  logic [chip8_sys_pkg::HOST_AW-1:0] address,
    input  logic [31:0]                        writedata,
    output logic [31:0]                        data_out,
    output logic                               sound_on
);
    import chip8_sys_pkg::*;

    host_if hbus ();
    exec_if xbus ();

    logic [MEM_AW-1:0] fetch_addr;
    logic [15:0]       fetch_word;
    logic [7:0]        dt_value;
    logic              dt_we;
    logic              st_we;
    logic [7:0]        dt_wdata;
    logic [7:0]        st_wdata;

    host_port u_host_port (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .data_out    (data_out),
        .host        (hbus.host)
    );

    run_control u_run_control (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .fetch_addr  (fetch_addr),
        .fetch_word  (fetch_word),
        .host        (hbus.ctrl),
        .ex          (xbus.ctrl)
    );

    chip8_memory u_memory (
        .clk        (clk),
        .host       (hbus.mem),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word)
    );

    chip8_timers u_timers (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .host        (hbus.timer),
        .dt_we       (dt_we),
        .st_we       (st_we),
        .dt_wdata    (dt_wdata),
        .st_wdata    (st_wdata),
        .dt_value    (dt_value),
        .sound_on    (sound_on)
    );

    exec_unit u_exec_unit (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .host        (hbus.exec),
        .ex          (xbus.unit),
        .dt_value    (dt_value),
        .dt_we       (dt_we),
        .st_we       (st_we),
        .dt_wdata    (dt_wdata),
        .st_wdata    (st_wdata)
    );

endmodule

// ==== exec_unit.sv ====
// Execution unit: V registers, I, call stack and decode of the executed opcode subset
`timescale 1ns/1ps

module exec_unit (
    input  logic       clk,
    input  logic       cpu_fbreset,
    host_if.exec       host,
    exec_if.unit       ex,
    input  logic [7:0] dt_value,
    output logic       dt_we,
    output logic       st_we,
    output logic [7:0] dt_wdata,
    output logic [7:0] st_wdata
);
    import chip8_sys_pkg::*;
    import chip8_isa_pkg::*;

    logic [7:0]        v [NUM_VREGS];
    logic [15:0]       i_reg;
    logic [MEM_AW-1:0] stack [STACK_DEPTH];
    logic [SP_W-1:0]   sp;
    logic              full;

    instr_u            ins;
    logic [7:0]        vx;
    logic              v_we;
    logic [3:0]        v_idx;
    logic [7:0]        v_wdata;
    logic              i_we;
    logic [15:0]       i_wdata;
    logic              push;
    logic              pop;
    pc_src_e           src;
    logic [MEM_AW-1:0] tgt;

    assign ins      = ex.instr;
    assign vx       = v[ins.imm_form.x];
    assign dt_wdata = vx;
    assign st_wdata = vx;
    assign full     = (sp == SP_W'(STACK_DEPTH - 1));

    always_comb begin
        v_we    = 1'b0;
        v_idx   = ins.imm_form.x;
        v_wdata = ins.imm_form.kk;
        i_we    = 1'b0;
        i_wdata = {4'h0, ins.addr_form.nnn};
        push    = 1'b0;
        pop     = 1'b0;
        dt_we   = 1'b0;
        st_we   = 1'b0;
        src     = NEXT;
        tgt     = ins.addr_form.nnn;
        if (ex.exec) begin
            case (ins.addr_form.op)
                OP_SYS: begin
                    if (ins.imm_form.x == 4'h0 && ins.imm_form.kk == KK_RET) begin
                        pop = 1'b1;
                        src = TARGET;
                        tgt = stack[sp - 1'b1];
                    end
                end
                OP_JP:   src = TARGET;
                OP_CALL: begin
                    push = 1'b1;
                    src  = TARGET;
                end
                OP_SE:   src = (vx == ins.imm_form.kk) ? SKIP : NEXT;
                OP_SNE:  src = (vx != ins.imm_form.kk) ? SKIP : NEXT;
                OP_LD:   v_we = 1'b1;
                OP_ADD: begin
                    // Carry is dropped
                    v_we    = 1'b1;
                    v_wdata = vx + ins.imm_form.kk;
                end
                OP_ALU: begin
                    if (ins.alu_form.n == 4'h0) begin
                        v_we    = 1'b1;
                        v_wdata = v[ins.alu_form.y];
                    end
                end
                OP_LDI:  i_we = 1'b1;
                OP_MISC: begin
                    case (ins.imm_form.kk)
                        KK_LD_VX_DT: begin
                            v_we    = 1'b1;
                            v_wdata = dt_value;
                        end
                        KK_LD_DT_VX: dt_we = 1'b1;
                        KK_LD_ST_VX: st_we = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end else if (host.we) begin
            if (host.target == VREG) begin
                v_we    = 1'b1;
                v_idx   = host.offset[3:0];
                v_wdata = host.wdata[7:0];
            end
            if (host.target == IREG) begin
                i_we    = 1'b1;
                i_wdata = host.wdata;
            end
        end
    end

    // Stack pointer saturates at both ends
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            sp        <= '0;
            ex.pc_src <= NEXT;
        end else begin
            if (push && !full) begin
                sp <= sp + 1'b1;
            end else if (pop && sp != '0) begin
                sp <= sp - 1'b1;
            end
            if (ex.exec) begin
                ex.pc_src <= src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (v_we) begin
            v[v_idx] <= v_wdata;
        end
        if (i_we) begin
            i_reg <= i_wdata;
        end
        if (push && !full) begin
            stack[sp] <= ex.pc + 12'd2;
        end
        if (ex.exec) begin
            ex.pc_target <= tgt;
        end
        case (host.target)
            VREG:      host.rdata_exec <= {8'h0, v[host.offset[3:0]]};
            IREG:      host.rdata_exec <= i_reg;
            STACK_SP:  host.rdata_exec <= {{(16 - SP_W){1'b0}}, sp};
            STACK_TOP: host.rdata_exec <= {4'h0, stack[sp - 1'b1]};
            default: ;
        endcase
    end

    a_timer_we_on_exec: assert property (@(posedge clk) disable iff (cpu_fbreset)
        (dt_we || st_we) |-> ex.exec && ins.addr_form.op == OP_MISC);

endmodule

// ==== host_port.sv ====
// Host bus front end: decodes chipselect/address into a target and returns registered read data
`timescale 1ns/1ps

module host_port (
    input  logic                               clk,
    input  logic                               cpu_fbreset,
    input  logic                               chipselect,
    input  logic                               write,
    input  logic [chip8_sys_pkg::HOST_AW-1:0] address,
    input  logic [31:0]                        writedata,
    output logic [31:0]                        data_out,
    host_if.host                               host
);
    import chip8_sys_pkg::*;

    logic [HOST_MEM_BIT-1:0] reg_addr;
    logic                    rd_pending;
    host_target_e            rd_target;
    logic [31:0]             rd_word;

    assign reg_addr   = address[HOST_MEM_BIT-1:0];
    assign host.offset = address[MEM_AW-1:0];
    assign host.wdata  = writedata[15:0];
    assign host.we     = chipselect & write;

    always_comb begin
        host.target = NONE;
        if (chipselect) begin
            if (address[HOST_MEM_BIT]) begin
                host.target = MEM;
            end else if (reg_addr < NUM_VREGS) begin
                host.target = VREG;
            end else begin
                case (reg_addr)
                    HADDR_I:     host.target = IREG;
                    HADDR_ST:    host.target = TIMER_ST;
                    HADDR_DT:    host.target = TIMER_DT;
                    HADDR_SP:    host.target = STACK_SP;
                    HADDR_PC:    host.target = CTRL_PC;
                    HADDR_STATE: host.target = CTRL_STATE;
                    HADDR_STACK: host.target = STACK_TOP;
                    default:     host.target = NONE;
                endcase
            end
        end
    end

    // Responder data is valid the cycle after the access
    always_comb begin
        case (rd_target)
            MEM:                               rd_word = {24'h0, host.rdata_mem};
            VREG, IREG, STACK_SP, STACK_TOP:   rd_word = {16'h0, host.rdata_exec};
            TIMER_ST, TIMER_DT:                rd_word = {24'h0, host.rdata_timer};
            CTRL_PC, CTRL_STATE:               rd_word = {16'h0, host.rdata_ctrl};
            default:                           rd_word = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            rd_pending <= 1'b0;
            rd_target  <= NONE;
            data_out   <= 32'h0;
        end else begin
            rd_pending <= chipselect & ~write;
            rd_target  <= host.target;
            if (rd_pending) begin
                data_out <= rd_word;
            end
        end
    end

    a_idle_target: assert property (@(posedge clk) disable iff (cpu_fbreset)
        !chipselect |-> host.target == NONE);

endmodule

// ==== run_control.sv ====
// Sequencer: run state, stage counter, PC, instruction fetch and the exec pulse
`timescale 1ns/1ps

module run_control (
    input  logic                              clk,
    input  logic                              cpu_fbreset,
    output logic [chip8_sys_pkg::MEM_AW-1:0] fetch_addr,
    input  logic [15:0]                       fetch_word,
    host_if.ctrl                              host,
    exec_if.ctrl                              ex
);
    import chip8_sys_pkg::*;
    import chip8_isa_pkg::*;

    run_state_e        state;
    logic [STAGE_W-1:0] stage;
    logic [MEM_AW-1:0] pc;
    logic              run_ok;

    // Any host access holds the sequencer for a cycle
    assign run_ok     = (state == RUNNING) && (host.target == NONE);
    assign ex.exec    = run_ok && (stage == STAGE_W'(2));
    assign ex.pc      = pc;
    assign fetch_addr = pc;

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            state <= PAUSED;
            stage <= '0;
            pc    <= PC_RESET;
        end else if (host.we && host.target == CTRL_STATE) begin
            state <= run_state_e'(host.wdata[1:0]);
            stage <= '0;
        end else if (host.we && host.target == CTRL_PC) begin
            pc    <= host.wdata[MEM_AW-1:0];
            stage <= '0;
        end else if (run_ok) begin
            if (stage == STAGE_LAST) begin
                stage <= '0;
                case (ex.pc_src)
                    SKIP:    pc <= pc + 12'd4;
                    TARGET:  pc <= ex.pc_target;
                    default: pc <= pc + 12'd2;
                endcase
            end else begin
                stage <= stage + 1'b1;
            end
        end
    end

    // Fetch word arrives one cycle after stage 0
    always_ff @(posedge clk) begin
        if (run_ok && stage == STAGE_W'(1)) begin
            ex.instr <= fetch_word;
        end
        if (host.target == CTRL_PC) begin
            host.rdata_ctrl <= {4'h0, pc};
        end else if (host.target == CTRL_STATE) begin
            host.rdata_ctrl <= {14'h0, state};
        end
    end

    // Stage 2 is only reached through the latch stage
    a_exec_stage: assert property (@(posedge clk) disable iff (cpu_fbreset)
        ex.exec |-> state == RUNNING && stage == STAGE_W'(2)
                    && $past(stage) inside {STAGE_W'(1), STAGE_W'(2)});

    a_stage_range: assert property (@(posedge clk) disable iff (cpu_fbreset)
        stage <= STAGE_LAST);

endmodule

// ==== src.f ====
chip8_sys_pkg.sv
chip8_isa_pkg.sv
chip8_ifs.sv
host_port.sv
run_control.sv
chip8_timers.sv
chip8_memory.sv
exec_unit.sv
chip8_top.sv
tb_chip8.sv

// ==== tb_chip8.sv ====
// Self-checking testbench for chip8_top; drives the host bus and checks results through assertions
`timescale 1ns/1ps

module tb_chip8;
    import chip8_sys_pkg::*;

    localparam int PERIOD_CYC  = int'(STAGE_LAST) + 1;
    localparam int HOST_CYC    = 600;
    localparam int PROG_RUNS   = 4;
    localparam int K_MAX       = 10;
    localparam int DT_READS    = 6;
    localparam int DT_GAP      = 24;
    localparam int CYCLE_LIMIT = 8 + HOST_CYC + PROG_RUNS * 40 * PERIOD_CYC
                                 + (K_MAX + 2) * TICK_DIV + DT_READS * (DT_GAP + 3);

    logic               clk;
    logic               cpu_fbreset;
    logic               chipselect;
    logic               write;
    logic [HOST_AW-1:0] address;
    logic [31:0]        writedata;
    logic [31:0]        data_out;
    logic               sound_on;

    logic [31:0] lfsr = 32'hff35;
    logic [31:0] exp_data;
    logic [31:0] last_read;
    string       chk_name;
    logic        chk_eq = 1'b0;
    logic        chk_le = 1'b0;
    logic        chk_quiet = 1'b0;
    logic        snd_watch = 1'b0;
    int          snd_cnt;
    int          snd_lo;
    int          snd_hi;
    int          cycle_cnt = 0;

    chip8_top UUT (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .data_out    (data_out),
        .sound_on    (sound_on)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                   input logic [31:0] act, input bit at_most);
        $display("MISMATCH at %0t ns: %s expected %s%h, got %h", $time, sig,
                 at_most ? "at most " : "", expv, act);
        $display("CHECKS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("At %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "check failed");
    endtask

    a_read_eq: assert property (@(posedge clk) chk_eq |-> data_out == exp_data)
        else report_mismatch(chk_name, exp_data, data_out, 1'b0);
    a_read_le: assert property (@(posedge clk) chk_le |-> data_out <= exp_data)
        else report_mismatch(chk_name, exp_data, data_out, 1'b1);
    a_quiet: assert property (@(posedge clk) chk_quiet |-> !sound_on)
        else report_mismatch("sound_on", 32'd0, 32'd1, 1'b0);
    a_sound_hold: assert property (@(posedge clk) snd_watch && snd_cnt < snd_lo |-> sound_on)
        else report_mismatch("sound_on", 32'd1, 32'd0, 1'b0);
    a_sound_fall: assert property (@(posedge clk) snd_watch |-> snd_cnt <= snd_hi)
        else report_failure("sound_on stayed high past the last allowed tick");

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        snd_cnt   <= snd_watch ? snd_cnt + 1 : 0;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [HOST_AW-1:0] mem_addr(input logic [MEM_AW-1:0] off);
        return {1'b1, 4'h0, off};
    endfunction

    // All host tasks start and end on a falling edge
    task automatic host_write(input logic [HOST_AW-1:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(negedge clk);
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic host_read(input logic [HOST_AW-1:0] addr, input logic [31:0] expv,
                             input bit at_most, input string name);
        chipselect = 1'b1;
        write      = 1'b0;
        address    = addr;
        @(negedge clk);
        chipselect = 1'b0;
        @(negedge clk);
        exp_data = expv;
        chk_name = name;
        chk_eq   = !at_most;
        chk_le   = at_most;
        @(negedge clk);
        chk_eq    = 1'b0;
        chk_le    = 1'b0;
        last_read = data_out;
    endtask

    task automatic load_instr(input logic [MEM_AW-1:0] at, input logic [15:0] word);
        host_write(mem_addr(at), {24'h0, word[15:8]});
        host_write(mem_addr(at + 12'd1), {24'h0, word[7:0]});
    endtask

    // Exactly n instruction periods between the two state writes
    task automatic run_periods(input int n);
        host_write({1'b0, HADDR_STATE}, 32'd0);
        repeat (n * PERIOD_CYC) @(negedge clk);
        host_write({1'b0, HADDR_STATE}, 32'd3);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [7:0]  vexp [16];
        logic [15:0] prog_main [18];
        logic [31:0] bound;
        int          k;
        int          depth;

        cpu_fbreset = 1'b1;
        chipselect  = 1'b0;
        write       = 1'b0;
        address     = '0;
        writedata   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        cpu_fbreset = 1'b0;

        chk_quiet = 1'b1;
        host_read({1'b0, HADDR_STATE}, 32'd3, 1'b0, "state");
        chk_quiet = 1'b0;
        host_read({1'b0, HADDR_PC}, 32'h200, 1'b0, "pc");
        host_read({1'b0, HADDR_SP}, 32'd0, 1'b0, "sp");

        for (int n = 0; n < 8; n++) begin
            draw_bits(12, r);
            draw_bits(8, d);
            host_write(mem_addr(r[11:0]), d);
            host_read(mem_addr(r[11:0]), d, 1'b0, $sformatf("mem[%h]", r[11:0]));
        end
        for (int n = 0; n < NUM_VREGS; n++) begin
            draw_bits(8, r);
            vexp[n] = r[7:0];
            host_write(HOST_AW'(n), r);
        end
        for (int n = 0; n < NUM_VREGS; n++) begin
            host_read(HOST_AW'(n), {24'h0, vexp[n]}, 1'b0, $sformatf("V%0d", n));
        end
        draw_bits(16, r);
        host_write({1'b0, HADDR_I}, r);
        host_read({1'b0, HADDR_I}, {16'h0, r[15:0]}, 1'b0, "I");
        host_read(17'h00015, 32'd0, 1'b0, "unmapped 0x15");
        host_read(17'h00020, 32'd0, 1'b0, "unmapped 0x20");

        // SE/SNE taken and not taken, CALL/RET, then a jump to itself at 0x21A
        prog_main = '{16'h6005, 16'h7003, 16'h8100, 16'hA123, 16'h3008, 16'h6177,
                      16'h3009, 16'h6233, 16'h4033, 16'h6255, 16'h4008, 16'h6366,
                      16'h2220, 16'h121A, 16'h0000, 16'h0000, 16'h6444, 16'h00EE};
        for (int n = 0; n < 18; n++) begin
            load_instr(12'h200 + 12'(2 * n), prog_main[n]);
        end
        run_periods(30);
        vexp[0] = 8'h08;
        vexp[1] = 8'h08;
        vexp[2] = 8'h33;
        vexp[3] = 8'h66;
        vexp[4] = 8'h44;
        for (int n = 0; n < NUM_VREGS; n++) begin
            host_read(HOST_AW'(n), {24'h0, vexp[n]}, 1'b0, $sformatf("V%0d", n));
        end
        host_read({1'b0, HADDR_I}, 32'h123, 1'b0, "I");
        host_read({1'b0, HADDR_PC}, 32'h21A, 1'b0, "pc");
        host_read({1'b0, HADDR_SP}, 32'd0, 1'b0, "sp");

        // Chain of calls, each one calling the next word
        for (int n = 0; n < 21; n++) begin
            load_instr(12'h300 + 12'(2 * n), 16'h2302 + 16'(2 * n));
        end
        host_write({1'b0, HADDR_PC}, 32'h300);
        for (int n = 0; n <= 20; n++) begin
            if (n == 5 || n == 20) begin
                run_periods(n == 5 ? 5 : 15);
                depth = (n < STACK_DEPTH - 1) ? n : STACK_DEPTH - 1;
                host_read({1'b0, HADDR_SP}, depth, 1'b0, "sp");
                host_read({1'b0, HADDR_STACK}, 32'h300 + 2 * depth, 1'b0, "stack top");
            end
        end

        draw_bits(3, r);
        k = 3 + int'(r[2:0]);
        if (k > K_MAX) begin
            k = K_MAX;
        end
        snd_lo = (k - 1) * TICK_DIV;
        snd_hi = (k + 1) * TICK_DIV;
        host_write({1'b0, HADDR_ST}, k);
        snd_watch = 1'b1;
        @(negedge clk);
        while (sound_on) @(negedge clk);
        snd_watch = 1'b0;

        draw_bits(7, r);
        bound = {24'h0, 1'b1, r[6:0]};
        host_write({1'b0, HADDR_DT}, bound);
        for (int n = 0; n < DT_READS; n++) begin
            repeat (DT_GAP) @(negedge clk);
            host_read({1'b0, HADDR_DT}, bound, 1'b1, "delay timer");
            bound = last_read;
        end

        // FX15 then FX07 copies the delay timer back into V4
        draw_bits(6, r);
        d = {24'h0, 2'b01, r[5:0]};
        load_instr(12'h3A0, {8'h63, d[7:0]});
        load_instr(12'h3A2, 16'hF315);
        load_instr(12'h3A4, 16'hF407);
        load_instr(12'h3A6, 16'h13A6);
        host_write({1'b0, HADDR_PC}, 32'h3A0);
        run_periods(6);
        host_read(HOST_AW'(3), d, 1'b0, "V3");
        host_read(HOST_AW'(4), d, 1'b1, "V4");
        host_read({1'b0, HADDR_PC}, 32'h3A6, 1'b0, "pc");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
